// File: common/sm83_config.svh
`ifndef SM83_CONFIG_SVH
`define SM83_CONFIG_SVH

// Machine-cycle slots per instruction; the last slot closes a failed condition
`define SM83_MAX_CYCLES 6

// Interrupt register addresses inside the I/O window
`define SM83_IF_ADDR 16'hFF0F
`define SM83_IE_ADDR 16'hFFFF

// Register values after reset
`define SM83_PC_RESET 16'h0000
`define SM83_SP_RESET 16'hFFFE

// Interrupt sources and their vector table
`define SM83_IRQ_COUNT 5
`define SM83_VECTOR_BASE 8'h40
`define SM83_IF_UNUSED 3'b111

`endif

// File: common/sm83_pkg.sv
package sm83_pkg;

  // Clock phase inside one machine cycle
  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_e;

  typedef enum logic [2:0] {
    ADDR_NONE, ADDR_PC, ADDR_SP, ADDR_HL, ADDR_WZ, ADDR_FF_Z
  } addr_src_e;

  typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} bus_op_e;

  // Read with REG_NONE is an opcode fetch into IR
  typedef enum logic [3:0] {
    REG_NONE, REG_A, REG_B, REG_H, REG_L, REG_Z, REG_W, REG_PCH, REG_PCL
  } reg_sel_e;

  typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC} idu_op_e;

  typedef enum logic [2:0] {
    ALU_NONE, ALU_LD, ALU_INC, ALU_DEC, ALU_ADD, ALU_ADD_REL
  } alu_op_e;

  typedef enum logic [2:0] {
    MISC_NONE, MISC_COND_NZ, MISC_JUMP_WZ, MISC_EI, MISC_DI, MISC_HALT, MISC_RETI,
    MISC_SET_VECTOR
  } misc_op_e;

  // Supported opcode subset
  typedef enum logic [7:0] {
    OP_NOP       = 8'h00,
    OP_DEC_B     = 8'h05,
    OP_LD_B_D8   = 8'h06,
    OP_JR_NZ     = 8'h20,
    OP_LD_HL_D16 = 8'h21,
    OP_INC_A     = 8'h3C,
    OP_LD_A_D8   = 8'h3E,
    OP_HALT      = 8'h76,
    OP_LD_HLM_A  = 8'h77,
    OP_LD_A_HLM  = 8'h7E,
    OP_ADD_A_B   = 8'h80,
    OP_JP_A16    = 8'hC3,
    OP_RETI      = 8'hD9,
    OP_LDH_A8_A  = 8'hE0,
    OP_DI        = 8'hF3,
    OP_EI        = 8'hFB
  } opcode_e;

  typedef struct packed {
    addr_src_e addr_src;
    bus_op_e   bus_op;
    reg_sel_e  bus_reg;
    idu_op_e   idu_op;
    alu_op_e   alu_op;
    reg_sel_e  alu_dst;
    reg_sel_e  alu_src;
    misc_op_e  misc_op;
    logic      last;
  } cycle_word_t;

  typedef struct packed {
    logic [7:0] result;
    logic       z;
    logic       n;
    logic       h;
    logic       c;
  } alu_result_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } bus_req_t;

endpackage

// File: cpu/microcode_rom.sv
module microcode_rom (
  input  logic [7:0]            opcode,
  input  logic                  dispatch,
  input  logic [2:0]            cycle_idx,
  output sm83_pkg::cycle_word_t cw
);
  import sm83_pkg::*;

  function automatic cycle_word_t bus_cycle(addr_src_e src, bus_op_e op, reg_sel_e r,
                                            idu_op_e idu, misc_op_e misc);
    cycle_word_t w;
    w = '0;
    w.addr_src = src;
    w.bus_op = op;
    w.bus_reg = r;
    w.idu_op = idu;
    w.misc_op = misc;
    return w;
  endfunction

  function automatic cycle_word_t internal(alu_op_e op, reg_sel_e dst, reg_sel_e src,
                                           misc_op_e misc);
    cycle_word_t w;
    w = '0;
    w.alu_op = op;
    w.alu_dst = dst;
    w.alu_src = src;
    w.misc_op = misc;
    return w;
  endfunction

  // Opcode fetch at PC, closes every instruction
  function automatic cycle_word_t fetch_with(alu_op_e op, reg_sel_e dst, reg_sel_e src,
                                             misc_op_e misc);
    cycle_word_t w;
    w = internal(op, dst, src, misc);
    w.addr_src = ADDR_PC;
    w.bus_op = BUS_READ;
    w.idu_op = IDU_INC;
    w.last = 1'b1;
    return w;
  endfunction

  // ====================================================================
  // Control store
  // ====================================================================
  always_comb begin
    if (dispatch) begin
      case (cycle_idx)
        // Undo the prefetch so the pushed PC is the interrupted opcode
        3'd0: cw = bus_cycle(ADDR_PC, BUS_NONE, REG_NONE, IDU_DEC, MISC_NONE);
        3'd1: cw = bus_cycle(ADDR_SP, BUS_NONE, REG_NONE, IDU_DEC, MISC_NONE);
        3'd2: cw = bus_cycle(ADDR_SP, BUS_WRITE, REG_PCH, IDU_DEC, MISC_NONE);
        3'd3: cw = bus_cycle(ADDR_SP, BUS_WRITE, REG_PCL, IDU_NONE, MISC_SET_VECTOR);
        default: cw = fetch_with(ALU_NONE, REG_NONE, REG_NONE, MISC_NONE);
      endcase
    end else begin
      case ({opcode, cycle_idx})
        {OP_NOP, 3'd0}:       cw = fetch_with(ALU_NONE, REG_NONE, REG_NONE, MISC_NONE);
        {OP_LD_A_D8, 3'd0}:   cw = bus_cycle(ADDR_PC, BUS_READ, REG_A, IDU_INC, MISC_NONE);
        {OP_LD_B_D8, 3'd0}:   cw = bus_cycle(ADDR_PC, BUS_READ, REG_B, IDU_INC, MISC_NONE);
        {OP_LD_HL_D16, 3'd0}: cw = bus_cycle(ADDR_PC, BUS_READ, REG_L, IDU_INC, MISC_NONE);
        {OP_LD_HL_D16, 3'd1}: cw = bus_cycle(ADDR_PC, BUS_READ, REG_H, IDU_INC, MISC_NONE);
        {OP_LD_HLM_A, 3'd0}:  cw = bus_cycle(ADDR_HL, BUS_WRITE, REG_A, IDU_NONE, MISC_NONE);
        {OP_LD_A_HLM, 3'd0}:  cw = bus_cycle(ADDR_HL, BUS_READ, REG_Z, IDU_NONE, MISC_NONE);
        {OP_LD_A_HLM, 3'd1}:  cw = fetch_with(ALU_LD, REG_A, REG_Z, MISC_NONE);
        {OP_LDH_A8_A, 3'd0}:  cw = bus_cycle(ADDR_PC, BUS_READ, REG_Z, IDU_INC, MISC_NONE);
        {OP_LDH_A8_A, 3'd1}:  cw = bus_cycle(ADDR_FF_Z, BUS_WRITE, REG_A, IDU_NONE, MISC_NONE);
        {OP_INC_A, 3'd0}:     cw = fetch_with(ALU_INC, REG_A, REG_NONE, MISC_NONE);
        {OP_DEC_B, 3'd0}:     cw = fetch_with(ALU_DEC, REG_B, REG_NONE, MISC_NONE);
        {OP_ADD_A_B, 3'd0}:   cw = fetch_with(ALU_ADD, REG_A, REG_B, MISC_NONE);
        {OP_JP_A16, 3'd0}:    cw = bus_cycle(ADDR_PC, BUS_READ, REG_Z, IDU_INC, MISC_NONE);
        {OP_JP_A16, 3'd1}:    cw = bus_cycle(ADDR_PC, BUS_READ, REG_W, IDU_INC, MISC_NONE);
        {OP_JP_A16, 3'd2}:    cw = internal(ALU_NONE, REG_NONE, REG_NONE, MISC_JUMP_WZ);
        // Failed condition continues at the closing slot
        {OP_JR_NZ, 3'd0}:     cw = bus_cycle(ADDR_PC, BUS_READ, REG_Z, IDU_INC, MISC_COND_NZ);
        {OP_JR_NZ, 3'd1}:     cw = internal(ALU_ADD_REL, REG_PCL, REG_Z, MISC_NONE);
        {OP_EI, 3'd0}:        cw = fetch_with(ALU_NONE, REG_NONE, REG_NONE, MISC_EI);
        {OP_DI, 3'd0}:        cw = fetch_with(ALU_NONE, REG_NONE, REG_NONE, MISC_DI);
        {OP_HALT, 3'd0}:      cw = fetch_with(ALU_NONE, REG_NONE, REG_NONE, MISC_HALT);
        {OP_RETI, 3'd0}:      cw = bus_cycle(ADDR_SP, BUS_READ, REG_Z, IDU_INC, MISC_NONE);
        {OP_RETI, 3'd1}:      cw = bus_cycle(ADDR_SP, BUS_READ, REG_W, IDU_INC, MISC_NONE);
        {OP_RETI, 3'd2}:      cw = internal(ALU_NONE, REG_NONE, REG_NONE, MISC_RETI);
        // Closing fetch of each instruction and every unknown opcode
        default:              cw = fetch_with(ALU_NONE, REG_NONE, REG_NONE, MISC_NONE);
      endcase
    end
  end

endmodule

// File: cpu/alu_idu.sv
module alu_idu (
  input  sm83_pkg::alu_op_e     alu_op,
  input  logic [7:0]            alu_a,
  input  logic [7:0]            alu_b,
  input  logic [3:0]            alu_flags_in,
  output sm83_pkg::alu_result_t alu_res,
  input  sm83_pkg::idu_op_e     idu_op,
  input  logic [15:0]           idu_in,
  output logic [15:0]           idu_out
);
  import sm83_pkg::*;

  logic [7:0] res;
  logic [8:0] sum;
  logic [4:0] half;

  // Flags in F order z, n, h, c
  always_comb begin
    sum = {1'b0, alu_a} + {1'b0, alu_b};
    half = {1'b0, alu_a[3:0]} + {1'b0, alu_b[3:0]};
    res = alu_a;
    {alu_res.z, alu_res.n, alu_res.h, alu_res.c} = alu_flags_in;
    case (alu_op)
      ALU_LD: res = alu_b;
      ALU_INC: begin
        res = alu_a + 8'd1;
        alu_res.z = (res == 8'h00);
        alu_res.n = 1'b0;
        alu_res.h = (alu_a[3:0] == 4'hF);
      end
      ALU_DEC: begin
        res = alu_a - 8'd1;
        alu_res.z = (res == 8'h00);
        alu_res.n = 1'b1;
        alu_res.h = (alu_a[3:0] == 4'h0);
      end
      ALU_ADD: begin
        res = sum[7:0];
        alu_res.z = (res == 8'h00);
        alu_res.n = 1'b0;
        alu_res.h = half[4];
        alu_res.c = sum[8];
      end
      // Low byte only, JR leaves the flags alone
      ALU_ADD_REL: res = sum[7:0];
      default: ;
    endcase
    alu_res.result = res;
  end

  // 16-bit path, also carries the full PC + e8 for JR
  always_comb begin
    if (alu_op == ALU_ADD_REL) begin
      idu_out = idu_in + {{8{alu_b[7]}}, alu_b};
    end else begin
      case (idu_op)
        IDU_INC: idu_out = idu_in + 16'd1;
        IDU_DEC: idu_out = idu_in - 16'd1;
        default: idu_out = idu_in;
      endcase
    end
  end

endmodule

// File: cpu/cpu_core.sv
`include "sm83_config.svh"

module cpu_core (
  input  logic                  clk,
  input  logic                  reset,
  output sm83_pkg::bus_req_t    core_bus,
  input  logic [7:0]            core_rdata,
  input  sm83_pkg::cycle_word_t cw,
  output logic [7:0]            opcode,
  output logic                  dispatch,
  output logic [2:0]            cycle_idx,
  output sm83_pkg::alu_op_e     alu_op,
  output logic [7:0]            alu_a,
  output logic [7:0]            alu_b,
  output logic [3:0]            alu_flags_in,
  input  sm83_pkg::alu_result_t alu_res,
  output sm83_pkg::idu_op_e     idu_op,
  output logic [15:0]           idu_in,
  input  logic [15:0]           idu_out,
  input  logic                  irq_pending,
  input  logic [2:0]            irq_index,
  output logic                  irq_ack
);
  import sm83_pkg::*;

  localparam logic [2:0] CLOSE_SLOT = 3'(`SM83_MAX_CYCLES - 1);

  t_phase_e    phase;
  logic [15:0] pc, sp, addr_val, bus_addr;
  logic [7:0]  a, b, h, l, w, z, ir, bus_wdata;
  logic [3:0]  flags;
  logic        ime, halted, rd_en, wr_en;
  logic [2:0]  vec_idx;
  logic        ime_now, at_end, enter_irq, cond_fail, alu_wb;

  function automatic logic [7:0] reg_read(reg_sel_e r);
    case (r)
      REG_A:   return a;
      REG_B:   return b;
      REG_H:   return h;
      REG_L:   return l;
      REG_W:   return w;
      REG_Z:   return z;
      REG_PCH: return pc[15:8];
      REG_PCL: return pc[7:0];
      default: return 8'h00;
    endcase
  endfunction

  always_comb begin
    case (cw.addr_src)
      ADDR_PC:   addr_val = pc;
      ADDR_SP:   addr_val = sp;
      ADDR_HL:   addr_val = {h, l};
      ADDR_WZ:   addr_val = {w, z};
      ADDR_FF_Z: addr_val = {8'hFF, z};
      default:   addr_val = 16'h0000;
    endcase
  end

  // IME as it stands once this cycle retires
  always_comb begin
    case (cw.misc_op)
      MISC_EI: ime_now = 1'b1;
      MISC_DI: ime_now = 1'b0;
      default: ime_now = ime;
    endcase
  end

  assign at_end    = (phase == T4) && cw.last;
  assign enter_irq = irq_pending && (halted ? ime : (at_end && ime_now));
  assign cond_fail = (cw.misc_op == MISC_COND_NZ) && flags[3];
  assign alu_wb    = cw.alu_op inside {ALU_LD, ALU_INC, ALU_DEC, ALU_ADD};
  assign irq_ack   = enter_irq;

  assign core_bus     = '{addr: bus_addr, wdata: bus_wdata, read_en: rd_en, write_en: wr_en};
  assign alu_op       = cw.alu_op;
  assign alu_flags_in = flags;
  assign idu_op       = cw.idu_op;
  assign idu_in       = (cw.alu_op == ALU_ADD_REL) ? pc : addr_val;

  // ALU operands picked from the register file
  always_comb begin
    alu_a = reg_read(cw.alu_dst);
    alu_b = reg_read(cw.alu_src);
  end

  // ====================================================================
  // Sequencer, PC/SP and interrupt entry
  // ====================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase <= T1;
      cycle_idx <= '0;
      opcode <= 8'h00;
      dispatch <= 1'b0;
      pc <= `SM83_PC_RESET;
      sp <= `SM83_SP_RESET;
      ime <= 1'b0;
      halted <= 1'b0;
      rd_en <= 1'b0;
      wr_en <= 1'b0;
    end else if (halted) begin
      // Any pending source wakes the core and IME only decides on dispatch
      if (irq_pending) halted <= 1'b0;
      if (enter_irq) begin
        dispatch <= 1'b1;
        ime <= 1'b0;
      end
    end else begin
      case (phase)
        T1: phase <= T2;
        T2: begin
          rd_en <= (cw.bus_op == BUS_READ);
          wr_en <= (cw.bus_op == BUS_WRITE);
          phase <= T3;
        end
        T3: phase <= T4;
        T4: begin
          rd_en <= 1'b0;
          wr_en <= 1'b0;
          phase <= T1;
          if (cw.idu_op != IDU_NONE && cw.addr_src == ADDR_PC) pc <= idu_out;
          if (cw.idu_op != IDU_NONE && cw.addr_src == ADDR_SP) sp <= idu_out;
          if (cw.alu_op == ALU_ADD_REL) pc <= idu_out;
          case (cw.misc_op)
            MISC_JUMP_WZ: pc <= {w, z};
            MISC_RETI: begin
              pc <= {w, z};
              ime <= 1'b1;
            end
            MISC_EI: ime <= 1'b1;
            MISC_DI: ime <= 1'b0;
            MISC_SET_VECTOR: pc <= {8'h00, `SM83_VECTOR_BASE + {2'b00, vec_idx, 3'b000}};
            default: ;
          endcase
          if (cond_fail) begin
            cycle_idx <= CLOSE_SLOT;
          end else if (cw.last) begin
            cycle_idx <= '0;
            opcode <= ir;
            dispatch <= enter_irq;
            if (enter_irq) ime <= 1'b0;
            if (cw.misc_op == MISC_HALT && !irq_pending) halted <= 1'b1;
          end else begin
            cycle_idx <= cycle_idx + 3'd1;
          end
        end
        default: phase <= T1;
      endcase
    end
  end

  // Register file and bus payload
  always_ff @(posedge clk) begin
    if (enter_irq) vec_idx <= irq_index;
    if (!halted) begin
      case (phase)
        T1: bus_addr <= addr_val;
        T2: if (cw.bus_op == BUS_WRITE) bus_wdata <= reg_read(cw.bus_reg);
        T3: begin
          if (cw.bus_op == BUS_READ) begin
            case (cw.bus_reg)
              REG_NONE: ir <= core_rdata;
              REG_A:    a <= core_rdata;
              REG_B:    b <= core_rdata;
              REG_H:    h <= core_rdata;
              REG_L:    l <= core_rdata;
              REG_W:    w <= core_rdata;
              REG_Z:    z <= core_rdata;
              default:  ;
            endcase
          end
        end
        T4: begin
          if (cw.idu_op != IDU_NONE && cw.addr_src == ADDR_HL) {h, l} <= idu_out;
          if (cw.idu_op != IDU_NONE && cw.addr_src == ADDR_WZ) {w, z} <= idu_out;
          if (alu_wb) begin
            case (cw.alu_dst)
              REG_A:   a <= alu_res.result;
              REG_B:   b <= alu_res.result;
              REG_H:   h <= alu_res.result;
              REG_L:   l <= alu_res.result;
              REG_W:   w <= alu_res.result;
              REG_Z:   z <= alu_res.result;
              default: ;
            endcase
          end
          if (cw.alu_op inside {ALU_INC, ALU_DEC, ALU_ADD}) begin
            flags <= {alu_res.z, alu_res.n, alu_res.h, alu_res.c};
          end
        end
        default: ;
      endcase
    end
  end

  // Strobes only in T3 and T4, with the address held since T1
  bus_strobe_window: assert property (@(posedge clk) disable iff (reset)
    (core_bus.read_en || core_bus.write_en) |->
      (phase inside {T3, T4}) && $stable(core_bus.addr));

endmodule

// File: source/interrupt_io.sv
`include "sm83_config.svh"

module interrupt_io (
  input  logic               clk,
  input  logic               reset,
  input  sm83_pkg::bus_req_t core_bus,
  output logic [7:0]         core_rdata,
  output sm83_pkg::bus_req_t mem_bus,
  input  logic [7:0]         mem_rdata,
  input  logic               vblank_req,
  input  logic               stat_req,
  input  logic               timer_req,
  input  logic               serial_req,
  input  logic               joypad_req,
  output logic               irq_pending,
  output logic [2:0]         irq_index,
  input  logic               irq_ack
);
  import sm83_pkg::*;

  logic [`SM83_IRQ_COUNT-1:0] if_q, if_next, req, pending;
  logic [7:0]                 ie_q;
  logic                       hit_if, hit_ie;

  // Bit order is priority order, vblank first
  assign req    = {joypad_req, serial_req, timer_req, stat_req, vblank_req};
  assign hit_if = (core_bus.addr == `SM83_IF_ADDR);
  assign hit_ie = (core_bus.addr == `SM83_IE_ADDR);

  always_comb begin
    if_next = if_q;
    if (core_bus.write_en && hit_if) if_next = core_bus.wdata[`SM83_IRQ_COUNT-1:0];
    if (irq_ack) if_next[irq_index] = 1'b0;
    // New requests win over an acknowledge in the same clock
    if_next = if_next | req;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_q <= '0;
      ie_q <= 8'h00;
    end else begin
      if_q <= if_next;
      if (core_bus.write_en && hit_ie) ie_q <= core_bus.wdata;
    end
  end

  // Register window is kept off the external bus
  always_comb begin
    mem_bus = core_bus;
    if (hit_if || hit_ie) begin
      mem_bus.read_en = 1'b0;
      mem_bus.write_en = 1'b0;
    end
  end

  assign core_rdata = hit_if ? {`SM83_IF_UNUSED, if_q} : (hit_ie ? ie_q : mem_rdata);

  assign pending     = if_q & ie_q[`SM83_IRQ_COUNT-1:0];
  assign irq_pending = |pending;

  always_comb begin
    irq_index = 3'd0;
    for (int i = `SM83_IRQ_COUNT - 1; i >= 0; i--) begin
      if (pending[i]) irq_index = 3'(i);
    end
  end

  ack_needs_pending: assert property (@(posedge clk) disable iff (reset)
    irq_ack |-> irq_pending);

endmodule

// File: source/sm83_top.sv
module sm83_top (
  input  logic               clk,
  input  logic               reset,
  output sm83_pkg::bus_req_t mem_bus,
  input  logic [7:0]         mem_rdata,
  input  logic               vblank_req,
  input  logic               stat_req,
  input  logic               timer_req,
  input  logic               serial_req,
  input  logic               joypad_req
);
  import sm83_pkg::*;

  // Core to interrupt unit
  bus_req_t    core_bus;
  logic [7:0]  core_rdata;
  logic        irq_pending;
  logic [2:0]  irq_index;
  logic        irq_ack;

  // Sequencer to control store
  cycle_word_t cw;
  logic [7:0]  opcode;
  logic        dispatch;
  logic [2:0]  cycle_idx;

  // Datapath
  alu_op_e     alu_op;
  logic [7:0]  alu_a;
  logic [7:0]  alu_b;
  logic [3:0]  alu_flags_in;
  alu_result_t alu_res;
  idu_op_e     idu_op;
  logic [15:0] idu_in;
  logic [15:0] idu_out;

  cpu_core u_core (.*);

  microcode_rom u_rom (.*);

  alu_idu u_alu (.*);

  interrupt_io u_irq (.*);

endmodule

// File: test/sm83_tb.sv
`include "sm83_config.svh"

module sm83_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import sm83_pkg::*;

  localparam int CLK_PERIOD       = 8;
  localparam int RESET_CYCLES     = 10;
  localparam int CYCLES_PER_WRITE = 600;
  localparam int PULSE_DELAY      = 40;
  // Cycles after the last expected write in which any write is an error
  localparam int TAIL_CYCLES      = 200;
  localparam int IRQ_LINES        = `SM83_IRQ_COUNT;

  logic                 clk;
  logic                 reset;
  bus_req_t             mem_bus;
  logic [7:0]           mem_rdata;
  logic [IRQ_LINES-1:0] req_lines;

  logic [7:0]  mem [0:65535];
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  int          pulse_after [$];
  int          pulse_line [$];
  int          write_count;
  logic        prev_write_en;
  logic        golden_loaded;

  sm83_top UUT (
    .clk        (clk),
    .reset      (reset),
    .mem_bus    (mem_bus),
    .mem_rdata  (mem_rdata),
    .vblank_req (req_lines[0]),
    .stat_req   (req_lines[1]),
    .timer_req  (req_lines[2]),
    .serial_req (req_lines[3]),
    .joypad_req (req_lines[4])
  );

  // Program memory answers in the same cycle while read_en is high
  assign mem_rdata = mem_bus.read_en ? mem[mem_bus.addr] : 8'hFF;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // ====================================================================
  // Golden file with program bytes, request pulses and expected writes
  // ====================================================================
  task automatic load_golden();
    int                fd;
    int                code;
    logic [7:0]        tag;
    logic [8*160-1:0]  rest;
    logic [15:0]       addr_v;
    logic [7:0]        data_v;
    int                n_v;
    int                line_v;
    // Unprogrammed bytes differ from address to address
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'(i ^ (i >> 8));
    end
    fd = $fopen("test/sm83_golden.txt", "r");
    if (fd == 0) begin
      stop_on_error("cannot open test/sm83_golden.txt");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "M" || tag == "W") begin
          code = $fscanf(fd, "%h %h", addr_v, data_v);
          if (code != 2) stop_on_error("malformed M or W record in golden file");
          if (tag == "M") begin
            mem[addr_v] = data_v;
          end else begin
            exp_addr.push_back(addr_v);
            exp_data.push_back(data_v);
          end
        end else if (tag == "R") begin
          code = $fscanf(fd, "%d %d", n_v, line_v);
          if (code != 2 || line_v < 0 || line_v >= IRQ_LINES) begin
            stop_on_error("malformed R record in golden file");
          end
          pulse_after.push_back(n_v);
          pulse_line.push_back(line_v);
        end else if (tag != "#") begin
          stop_on_error("unknown record type in golden file");
        end
        // Rest of the line is free text
        code = $fgets(rest, fd);
      end
      $fclose(fd);
      if (exp_addr.size() == 0) stop_on_error("golden file holds no expected writes");
    end
  endtask

  task automatic check_write(input int idx);
    assert (idx < exp_addr.size()) else begin
      stop_on_error($sformatf("unexpected write of %02h to %04h after the last expected write",
                              mem_bus.wdata, mem_bus.addr));
    end
    if (idx < exp_addr.size()) begin
      assert (mem_bus.addr == exp_addr[idx]) else begin
        stop_on_error($sformatf("MISMATCH mem_bus.addr write %0d expected %04h actual %04h",
                                idx, exp_addr[idx], mem_bus.addr));
      end
      assert (mem_bus.wdata == exp_data[idx]) else begin
        stop_on_error($sformatf("MISMATCH mem_bus.wdata write %0d expected %02h actual %02h",
                                idx, exp_data[idx], mem_bus.wdata));
      end
    end
  endtask

  // ====================================================================
  // Main sequence and write monitor
  // ====================================================================
  initial begin : main_sequence
    int tail;
    reset = 1'b1;
    write_count = 0;
    prev_write_en = 1'b0;
    golden_loaded = 1'b0;
    tail = 0;
    load_golden();
    golden_loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    while (tail < TAIL_CYCLES) begin
      @(negedge clk);
      // One write per rising edge of write_en
      if (mem_bus.write_en && !prev_write_en) begin
        check_write(write_count);
        mem[mem_bus.addr] = mem_bus.wdata;
        write_count++;
      end
      prev_write_en = mem_bus.write_en;
      if (write_count == exp_addr.size()) tail++;
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  // One-clock request strobes counted from the n-th write
  initial begin : request_pulses
    req_lines = '0;
    while (golden_loaded !== 1'b1) @(posedge clk);
    for (int k = 0; k < pulse_after.size(); k++) begin
      while (write_count < pulse_after[k]) @(posedge clk);
      repeat (PULSE_DELAY) @(negedge clk);
      req_lines = IRQ_LINES'(1 << pulse_line[k]);
      @(negedge clk);
      req_lines = '0;
    end
  end

  initial begin : watchdog
    int limit;
    while (golden_loaded !== 1'b1) @(posedge clk);
    limit = RESET_CYCLES + exp_addr.size() * CYCLES_PER_WRITE + TAIL_CYCLES;
    repeat (limit) @(posedge clk);
    stop_on_error($sformatf("timeout, the program did not finish: %0d of %0d writes in %0d cycles",
                            write_count, exp_addr.size(), limit));
  end

endmodule

// File: test/sm83_golden.txt
# M addr data = program byte, W addr data = next expected write (hex)
# R n line = pulse request line (0 vblank .. 4 joypad) 40 cycles after write n (decimal)
M 0000 21  ; LD HL,C000
M 0001 00
M 0002 C0
M 0003 3E  ; LD A,3C
M 0004 3C
M 0005 3C  ; INC A
M 0006 77  ; LD (HL),A
M 0007 06  ; LD B,C5
M 0008 C5
M 0009 80  ; ADD A,B
M 000A E0  ; LDH (80),A
M 000B 80
M 000C 7E  ; LD A,(HL)
M 000D 3C  ; INC A
M 000E E0  ; LDH (81),A
M 000F 81
M 0010 06  ; LD B,04
M 0011 04
M 0012 3C  ; loop: INC A
M 0013 77  ; LD (HL),A
M 0014 05  ; DEC B
M 0015 20  ; JR NZ,loop
M 0016 FB
M 0017 C3  ; JP 001B
M 0018 1B
M 0019 00
M 001A 77  ; skipped LD (HL),A
M 001B 3E  ; LD A,14
M 001C 14
M 001D E0  ; LDH (FF),A  IE = timer and joypad
M 001E FF
M 001F 3E  ; LD A,04
M 0020 04
M 0021 E0  ; LDH (0F),A  IF = timer
M 0022 0F
M 0023 FB  ; EI
M 0024 3E  ; LD A,A5
M 0025 A5
M 0026 E0  ; LDH (82),A
M 0027 82
M 0028 3C  ; INC A
M 0029 77  ; LD (HL),A
M 002A 76  ; HALT
M 002B 00  ; NOP
M 0050 3E  ; timer handler: LD A,50
M 0051 50
M 0052 77  ; LD (HL),A
M 0053 D9  ; RETI
M 0060 3E  ; joypad handler: LD A,60
M 0061 60
M 0062 E0  ; LDH (83),A
M 0063 83
M 0064 C3  ; JP 0064
M 0065 64
M 0066 00
R 12 4     ; joypad while halted
W C000 3D  ; 3C + 1
W FF80 02  ; 3D + C5 drops the carry
W FF81 3E  ; reloaded 3D + 1
W C000 3F  ; loop pass 1
W C000 40  ; loop pass 2
W C000 41  ; loop pass 3
W C000 42  ; loop pass 4
W FFFD 00  ; timer push PCH
W FFFC 24  ; timer push PCL
W C000 50  ; timer handler marker
W FF82 A5  ; after RETI
W C000 A6  ; marker before HALT
W FFFD 00  ; joypad push PCH
W FFFC 2B  ; joypad push PCL
W FF83 60  ; joypad handler marker

// File: src.f
+incdir+common
common/sm83_pkg.sv
cpu/microcode_rom.sv
cpu/alu_idu.sv
cpu/cpu_core.sv
source/interrupt_io.sv
source/sm83_top.sv
test/sm83_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module sm83_tb \
  -f src.f -o sm83_sim || exit 1
out=$(./obj_dir/sm83_sim 2>&1)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
